/* filelist.f */
source/aluPkg.sv
source/operationDecoder.sv
source/executeRegister.sv
source/alu.sv
source/aluExecute.sv
verification/aluExecute_checker.sv
verification/aluExecuteTb.sv

/* runSim.sh */
#!/bin/sh
# Build the ALU execute stage with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
    --top-module aluExecuteTb -f filelist.f -o aluExecuteSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Raise the error limit so the run reaches its summary after an assertion fires
./obj_dir/aluExecuteSim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" "$LOG"; then
    echo "Failure reported in $LOG"
    exit 1
fi
exit 0

/* source/alu.sv */
`timescale 1ns/10ps

module alu (
    input  logic               clk,
    input  logic               rst,
    input  logic               stageValid,
    input  aluPkg::decodedOp_t stageOp,
    output logic               outValid,
    output aluPkg::word_t      result,
    output aluPkg::aluFlags_t  flags
);
    import aluPkg::*;

    word_t                 a;
    word_t                 b;
    shamt_t                shiftAmount;
    logic                  isSubtract;
    logic                  isAddSub;
    logic                  isSigned;
    word_t                 adderB;      // b or its inverse
    logic [DATA_WIDTH:0]   sum;         // Extra bit is the carry out
    logic                  signedOverflow;
    word_t                 nextResult;
    aluFlags_t             nextFlags;

    // Leading ones or zeros from the top bit, full width when none differ
    function automatic word_t countLeading(input word_t value, input logic target);
        word_t count;
        logic  stop;
        count = '0;
        stop  = 1'b0;
        for (int i = DATA_WIDTH - 1; i >= 0; i--)
        begin
            if (!stop && (value[i] == target))
            begin
                count = count + 1'b1;
            end
            else
            begin
                stop = 1'b1;
            end
        end
        return count;
    endfunction

    assign a           = stageOp.operandA;
    assign b           = stageOp.operandB;
    assign shiftAmount = b[4:0];  // Low bits only, as MIPS

    assign isSubtract = (stageOp.operation == ALU_SUB) || (stageOp.operation == ALU_SUBU);
    assign isSigned   = (stageOp.operation == ALU_ADD) || (stageOp.operation == ALU_SUB);
    assign isAddSub   = isSubtract || isSigned || (stageOp.operation == ALU_ADDU);

    // One 33-bit adder for all four add/sub forms
    assign adderB = isSubtract ? ~b : b;
    assign sum    = {1'b0, a} + {1'b0, adderB} + {{DATA_WIDTH{1'b0}}, isSubtract};

    // Same input signs but result sign differs
    assign signedOverflow = (a[DATA_WIDTH-1] == adderB[DATA_WIDTH-1]) &&
                            (sum[DATA_WIDTH-1] != a[DATA_WIDTH-1]);

    always_comb
    begin
        case (stageOp.operation)
            ALU_AND:  nextResult = a & b;
            ALU_OR:   nextResult = a | b;
            ALU_XOR:  nextResult = a ^ b;
            ALU_NOR:  nextResult = ~(a | b);
            ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU:
                nextResult = sum[DATA_WIDTH-1:0];
            ALU_SLL:  nextResult = a << shiftAmount;
            ALU_SRL:  nextResult = a >> shiftAmount;
            ALU_SRA:  nextResult = word_t'($signed(a) >>> shiftAmount); // Sign fill
            ALU_SLT:  nextResult = word_t'($signed(a) < $signed(b));
            ALU_SLTU: nextResult = word_t'(a < b);
            ALU_CLO:  nextResult = countLeading(a, 1'b1);
            ALU_CLZ:  nextResult = countLeading(a, 1'b0);
            ALU_LUI:  nextResult = {b[15:0], 16'h0000}; // Immediate to upper half
            default:  nextResult = '0;
        endcase
    end

    always_comb
    begin
        nextFlags.zero     = (nextResult == '0);
        nextFlags.negative = nextResult[DATA_WIDTH-1];
        nextFlags.carry    = isAddSub && sum[DATA_WIDTH]; // Set means no borrow on subtract
        nextFlags.overflow = isSigned && signedOverflow;
        nextFlags.illegal  = stageOp.illegal;
    end

    // Output stage, holds last item while idle
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            outValid <= 1'b0;
            result   <= '0;
            flags    <= '0;
        end
        else
        begin
            outValid <= stageValid;
            if (stageValid)
            begin
                result <= nextResult;
                flags  <= nextFlags;
            end
        end
    end

endmodule

/* source/aluExecute.sv */
`timescale 1ns/10ps

module aluExecute (
    input  logic              clk,
    input  logic              rst,
    input  logic              inValid,
    input  aluPkg::word_t     instruction,
    input  aluPkg::word_t     rsValue,
    input  aluPkg::word_t     rtValue,
    output logic              outValid,
    output aluPkg::word_t     result,
    output aluPkg::aluFlags_t flags
);
    import aluPkg::*;

    decodedOp_t decodedOp;  // Decoder output, combinational
    decodedOp_t stageOp;    // Registered item
    logic       stageValid;

    // Decode and operand select
    operationDecoder decoder (
        .instruction (instruction),
        .rsValue     (rsValue),
        .rtValue     (rtValue),
        .decoded     (decodedOp)
    );

    // One cycle between decode and execute
    executeRegister stageReg (
        .clk        (clk),
        .rst        (rst),
        .inValid    (inValid),
        .decoded    (decodedOp),
        .stageValid (stageValid),
        .stageOp    (stageOp)
    );

    // Execute, result and flags registered
    alu execUnit (
        .clk        (clk),
        .rst        (rst),
        .stageValid (stageValid),
        .stageOp    (stageOp),
        .outValid   (outValid),
        .result     (result),
        .flags      (flags)
    );

endmodule

/* source/aluPkg.sv */
package aluPkg;

    // Word size is fixed by the 32-bit instruction set
    localparam int DATA_WIDTH = 32;

    typedef logic [DATA_WIDTH-1:0] word_t;  // Operands and results
    typedef logic [4:0]            shamt_t; // Shift amount field
    typedef logic [5:0]            opcode_t;
    typedef logic [5:0]            funct_t;
    typedef logic [15:0]           imm_t;   // Immediate field of I-type

    // ALU operations
    // Variable shifts reuse SLL/SRL/SRA, the amount is moved into operandB by the decoder
    typedef enum logic [5:0] {
        ALU_AND  = 6'b000000,
        ALU_OR   = 6'b000001,
        ALU_XOR  = 6'b000010,
        ALU_NOR  = 6'b000011,
        ALU_ADDU = 6'b000100,
        ALU_SUBU = 6'b000101,
        ALU_ADD  = 6'b000110, // Signed, overflow flagged
        ALU_SUB  = 6'b000111, // Signed, overflow flagged
        ALU_SLL  = 6'b001000,
        ALU_SRL  = 6'b001010,
        ALU_SLT  = 6'b001100,
        ALU_SLTU = 6'b001101,
        ALU_CLO  = 6'b001110,
        ALU_CLZ  = 6'b001111,
        ALU_SRA  = 6'b010000,
        ALU_LUI  = 6'b010010
    } aluOperation_t;

    // Major opcodes
    localparam opcode_t OP_SPECIAL  = 6'b000000; // R-type, funct decides
    localparam opcode_t OP_SPECIAL2 = 6'b011100; // CLO and CLZ live here
    localparam opcode_t OP_BEQ      = 6'b000100;
    localparam opcode_t OP_BNE      = 6'b000101;
    localparam opcode_t OP_ADDI     = 6'b001000;
    localparam opcode_t OP_ADDIU    = 6'b001001;
    localparam opcode_t OP_SLTI     = 6'b001010;
    localparam opcode_t OP_SLTIU    = 6'b001011;
    localparam opcode_t OP_ANDI     = 6'b001100;
    localparam opcode_t OP_ORI      = 6'b001101;
    localparam opcode_t OP_XORI     = 6'b001110;
    localparam opcode_t OP_LUI      = 6'b001111;
    localparam opcode_t OP_LB       = 6'b100000; // Loads
    localparam opcode_t OP_LH       = 6'b100001;
    localparam opcode_t OP_LW       = 6'b100011;
    localparam opcode_t OP_LBU      = 6'b100100;
    localparam opcode_t OP_LHU      = 6'b100101;
    localparam opcode_t OP_SB       = 6'b101000; // Stores
    localparam opcode_t OP_SH       = 6'b101001;
    localparam opcode_t OP_SW       = 6'b101011;

    // SPECIAL function codes
    localparam funct_t FN_SLL  = 6'b000000;
    localparam funct_t FN_SRL  = 6'b000010;
    localparam funct_t FN_SRA  = 6'b000011;
    localparam funct_t FN_SLLV = 6'b000100;
    localparam funct_t FN_SRLV = 6'b000110;
    localparam funct_t FN_SRAV = 6'b000111;
    localparam funct_t FN_ADD  = 6'b100000;
    localparam funct_t FN_ADDU = 6'b100001;
    localparam funct_t FN_SUB  = 6'b100010;
    localparam funct_t FN_SUBU = 6'b100011;
    localparam funct_t FN_AND  = 6'b100100;
    localparam funct_t FN_OR   = 6'b100101;
    localparam funct_t FN_XOR  = 6'b100110;
    localparam funct_t FN_NOR  = 6'b100111;
    localparam funct_t FN_SLT  = 6'b101010;
    localparam funct_t FN_SLTU = 6'b101011;

    // SPECIAL2 function codes
    localparam funct_t FN_CLZ  = 6'b100000;
    localparam funct_t FN_CLO  = 6'b100001;

    // Decoded item between decode and execute
    typedef struct packed {
        aluOperation_t operation;
        word_t         operandA;
        word_t         operandB;
        logic          illegal;   // Unknown encoding
    } decodedOp_t;

    // Status flags next to the result
    typedef struct packed {
        logic zero;
        logic negative;
        logic carry;     // Add/sub only, no-borrow on subtract
        logic overflow;  // Signed ADD/SUB only
        logic illegal;
    } aluFlags_t;

endpackage

/* source/executeRegister.sv */
`timescale 1ns/10ps

module executeRegister (
    input  logic               clk,
    input  logic               rst,
    input  logic               inValid,
    input  aluPkg::decodedOp_t decoded,
    output logic               stageValid,
    output aluPkg::decodedOp_t stageOp
);
    import aluPkg::*;

    decodedOp_t opHold; // Decoded item in flight

    // Strobe only, cleared on reset
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            stageValid <= 1'b0;
        end
        else
        begin
            stageValid <= inValid;
        end
    end

    // Payload captured every cycle, valid tells if it counts
    always_ff @(posedge clk)
    begin
        opHold <= decoded;
    end

    assign stageOp = opHold;

endmodule

/* source/operationDecoder.sv */
`timescale 1ns/10ps

module operationDecoder (
    input  aluPkg::word_t      instruction,
    input  aluPkg::word_t      rsValue,
    input  aluPkg::word_t      rtValue,
    output aluPkg::decodedOp_t decoded
);
    import aluPkg::*;

    opcode_t opcode;
    funct_t  funct;
    shamt_t  shamt;
    imm_t    immediate;
    word_t   immSigned;  // For arithmetic, compares and addresses
    word_t   immZero;    // For logic immediates and LUI

    // Instruction fields
    assign opcode    = instruction[31:26];
    assign funct     = instruction[5:0];
    assign shamt     = instruction[10:6];
    assign immediate = instruction[15:0];

    assign immSigned = {{(DATA_WIDTH - 16){immediate[15]}}, immediate};
    assign immZero   = {{(DATA_WIDTH - 16){1'b0}}, immediate};

    always_comb
    begin
        // Default R-type operands
        decoded.operation = ALU_AND;
        decoded.operandA  = rsValue;
        decoded.operandB  = rtValue;
        decoded.illegal   = 1'b0;

        case (opcode)
            OP_SPECIAL:
            begin
                case (funct)
                    FN_AND:  decoded.operation = ALU_AND;
                    FN_OR:   decoded.operation = ALU_OR;
                    FN_XOR:  decoded.operation = ALU_XOR;
                    FN_NOR:  decoded.operation = ALU_NOR;
                    FN_ADD:  decoded.operation = ALU_ADD;
                    FN_ADDU: decoded.operation = ALU_ADDU;
                    FN_SUB:  decoded.operation = ALU_SUB;
                    FN_SUBU: decoded.operation = ALU_SUBU;
                    FN_SLT:  decoded.operation = ALU_SLT;
                    FN_SLTU: decoded.operation = ALU_SLTU;
                    FN_SLL, FN_SRL, FN_SRA:
                    begin
                        // rt shifted by the shamt field
                        decoded.operandA = rtValue;
                        decoded.operandB = word_t'(shamt);
                        decoded.operation = (funct == FN_SLL) ? ALU_SLL :
                                            (funct == FN_SRL) ? ALU_SRL : ALU_SRA;
                    end
                    FN_SLLV, FN_SRLV, FN_SRAV:
                    begin
                        // Swapped, amount comes from rs
                        decoded.operandA = rtValue;
                        decoded.operandB = rsValue;
                        decoded.operation = (funct == FN_SLLV) ? ALU_SLL :
                                            (funct == FN_SRLV) ? ALU_SRL : ALU_SRA;
                    end
                    default: decoded.illegal = 1'b1;
                endcase
            end

            OP_SPECIAL2:
            begin
                case (funct)
                    FN_CLO:  decoded.operation = ALU_CLO; // Counts on rs
                    FN_CLZ:  decoded.operation = ALU_CLZ;
                    default: decoded.illegal = 1'b1;
                endcase
            end

            // Sign-extended immediates
            OP_ADDI:
            begin
                decoded.operation = ALU_ADD;
                decoded.operandB  = immSigned;
            end
            OP_ADDIU:
            begin
                decoded.operation = ALU_ADDU;
                decoded.operandB  = immSigned;
            end
            OP_SLTI:
            begin
                decoded.operation = ALU_SLT;
                decoded.operandB  = immSigned;
            end
            OP_SLTIU:
            begin
                decoded.operation = ALU_SLTU;  // Immediate still sign extended, as in MIPS
                decoded.operandB  = immSigned;
            end

            // Zero-extended immediates
            OP_ANDI:
            begin
                decoded.operation = ALU_AND;
                decoded.operandB  = immZero;
            end
            OP_ORI:
            begin
                decoded.operation = ALU_OR;
                decoded.operandB  = immZero;
            end
            OP_XORI:
            begin
                decoded.operation = ALU_XOR;
                decoded.operandB  = immZero;
            end
            OP_LUI:
            begin
                decoded.operation = ALU_LUI;
                decoded.operandB  = immZero;
            end

            // Address add rs + offset
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW:
            begin
                decoded.operation = ALU_ADDU;
                decoded.operandB  = immSigned;
            end

            // Compare for branch, zero flag tells equality
            OP_BEQ, OP_BNE: decoded.operation = ALU_SUBU;

            default: decoded.illegal = 1'b1;
        endcase

        // Unknown encodings give a clean zero result
        if (decoded.illegal)
        begin
            decoded.operation = ALU_AND;
            decoded.operandA  = '0;
            decoded.operandB  = '0;
        end
    end

endmodule

/* verification/aluExecuteTb.sv */
`timescale 1ns/10ps

module aluExecuteTb;
    import aluPkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_RANDOM = 32;

    // One table row, flags packed as zero negative carry overflow illegal
    typedef struct packed {
        word_t     instruction;
        word_t     rsValue;
        word_t     rtValue;
        word_t     expResult;
        aluFlags_t expFlags;
    } stimEntry_t;

    logic       clk = 1'b0;
    logic       rst;
    logic       inValid;
    word_t      instruction;
    word_t      rsValue;
    word_t      rtValue;
    logic       outValid;
    word_t      result;
    aluFlags_t  flags;

    stimEntry_t  stimTable[$];
    stimEntry_t  expectQ[$];       // Scoreboard, oldest item first
    word_t       heldResult = '0;  // Output expected while outValid is low
    aluFlags_t   heldFlags = '0;
    logic [31:0] rngState = 32'h78de;
    logic        tableReady = 1'b0;
    int          passCount = 0;
    int          failCount = 0;

    aluExecute DUT (
        .clk         (clk),
        .rst         (rst),
        .inValid     (inValid),
        .instruction (instruction),
        .rsValue     (rsValue),
        .rtValue     (rtValue),
        .outValid    (outValid),
        .result      (result),
        .flags       (flags)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Register numbers are arbitrary, only the operand values matter
    function automatic word_t rType(input opcode_t op, input funct_t fn, input shamt_t sa);
        return {op, 5'd1, 5'd2, 5'd3, sa, fn};
    endfunction

    function automatic word_t iType(input opcode_t op, input imm_t imm);
        return {op, 5'd1, 5'd2, imm};
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] v;
        v = x ^ (x << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic void addEntry(input word_t instr, input word_t rs, input word_t rt,
                                     input word_t res, input logic [4:0] fl);
        stimTable.push_back({instr, rs, rt, res, aluFlags_t'(fl)});
    endfunction

    // Expected values worked out by hand
    function automatic void fillTable();
        addEntry(rType(OP_SPECIAL, FN_AND, 0), 32'hF0F0F0F0, 32'hFF00FF00, 32'hF000F000, 5'b01000);
        addEntry(rType(OP_SPECIAL, FN_OR, 0), 32'h0F0F0000, 32'h00F000F0, 32'h0FFF00F0, 5'b00000);
        addEntry(rType(OP_SPECIAL, FN_XOR, 0), 32'hFFFF0000, 32'hFF00FF00, 32'h00FFFF00, 5'b00000);
        addEntry(rType(OP_SPECIAL, FN_NOR, 0), 32'h0, 32'h0, 32'hFFFFFFFF, 5'b01000);
        addEntry(iType(OP_ANDI, 16'hFFFF), 32'h12345678, 32'h0, 32'h00005678, 5'b00000);
        addEntry(iType(OP_ORI, 16'h8000), 32'h0, 32'h0, 32'h00008000, 5'b00000);
        addEntry(iType(OP_XORI, 16'hFFFF), 32'hFFFFFFFF, 32'h0, 32'hFFFF0000, 5'b01000);
        addEntry(rType(OP_SPECIAL, FN_ADD, 0), 32'h7FFFFFFF, 32'h1, 32'h80000000, 5'b01010);
        addEntry(rType(OP_SPECIAL, FN_ADDU, 0), 32'hFFFFFFFF, 32'h1, 32'h0, 5'b10100);
        addEntry(rType(OP_SPECIAL, FN_SUB, 0), 32'h5, 32'h5, 32'h0, 5'b10100);
        addEntry(rType(OP_SPECIAL, FN_SUB, 0), 32'h80000000, 32'h1, 32'h7FFFFFFF, 5'b00110);
        addEntry(rType(OP_SPECIAL, FN_SUBU, 0), 32'h3, 32'h5, 32'hFFFFFFFE, 5'b01000);
        addEntry(iType(OP_ADDI, 16'hFFFC), 32'h10, 32'h0, 32'hC, 5'b00100);
        addEntry(iType(OP_LW, 16'h0010), 32'h1000, 32'h0, 32'h1010, 5'b00000);
        addEntry(iType(OP_SW, 16'hFFF0), 32'h1000, 32'h0, 32'h0FF0, 5'b00100);
        addEntry(iType(OP_BEQ, 16'h0004), 32'h7, 32'h7, 32'h0, 5'b10100);
        addEntry(rType(OP_SPECIAL, FN_SLL, 4), 32'hFFFFFFFF, 32'hF, 32'hF0, 5'b00000);
        addEntry(rType(OP_SPECIAL, FN_SRL, 8), 32'h0, 32'h80000000, 32'h00800000, 5'b00000);
        addEntry(rType(OP_SPECIAL, FN_SRA, 4), 32'h0, 32'h80000000, 32'hF8000000, 5'b01000);
        addEntry(rType(OP_SPECIAL, FN_SLLV, 0), 32'h23, 32'h1, 32'h8, 5'b00000); // Amount 3
        addEntry(rType(OP_SPECIAL, FN_SRLV, 0), 32'h1F, 32'hFFFFFFFF, 32'h1, 5'b00000);
        addEntry(rType(OP_SPECIAL, FN_SRAV, 0), 32'h4, 32'hF0000000, 32'hFF000000, 5'b01000);
        addEntry(rType(OP_SPECIAL, FN_SLT, 0), 32'hFFFFFFFF, 32'h1, 32'h1, 5'b00000);
        addEntry(rType(OP_SPECIAL, FN_SLTU, 0), 32'hFFFFFFFF, 32'h1, 32'h0, 5'b10000);
        addEntry(iType(OP_SLTIU, 16'hFFFF), 32'h5, 32'h0, 32'h1, 5'b00000);
        addEntry(rType(OP_SPECIAL2, FN_CLO, 0), 32'hFFFFFFFF, 32'h0, 32'd32, 5'b00000);
        addEntry(rType(OP_SPECIAL2, FN_CLO, 0), 32'hFFFF0000, 32'h0, 32'd16, 5'b00000);
        addEntry(rType(OP_SPECIAL2, FN_CLZ, 0), 32'h0, 32'h0, 32'd32, 5'b00000);
        addEntry(rType(OP_SPECIAL2, FN_CLZ, 0), 32'h00010000, 32'h0, 32'd15, 5'b00000);
        addEntry(iType(6'b111111, 16'h0), 32'h12345678, 32'h9, 32'h0, 5'b10001);
        addEntry(rType(OP_SPECIAL, 6'b001000, 0), 32'h1, 32'h2, 32'h0, 5'b10001); // JR unsupported
        addEntry(iType(OP_LUI, 16'h1234), 32'hAAAA5555, 32'h0, 32'h12340000, 5'b00000);
    endfunction

    task automatic driveItem(input stimEntry_t item);
        @(posedge clk);
        inValid     <= 1'b1;
        instruction <= item.instruction;
        rsValue     <= item.rsValue;
        rtValue     <= item.rtValue;
        expectQ.push_back(item);
    endtask

    // Scoreboard, outputs are stable at the falling edge
    always @(negedge clk)
    begin
        stimEntry_t expected;
        if (outValid === 1'b1)
        begin
            if (expectQ.size() == 0)
            begin
                failCount++;
                $display("outValid rose at %0t with no item pending", $time);
            end
            else
            begin
                expected = expectQ.pop_front();
                if (result !== expected.expResult || flags !== expected.expFlags)
                begin
                    failCount++;
                    $display("FAILED at %0t: instr %h gave %h flags %b, expected %h flags %b",
                             $time, expected.instruction, result, flags,
                             expected.expResult, expected.expFlags);
                end
                else
                begin
                    passCount++;
                    $display("ok instr %h result %h flags %b", expected.instruction, result, flags);
                end
                heldResult = expected.expResult;
                heldFlags  = expected.expFlags;
            end
        end
        else if (rst === 1'b1)
        begin
            heldResult = '0;  // Reset clears the output stage
            heldFlags  = '0;
        end
        else if (result !== heldResult || flags !== heldFlags)
        begin
            failCount++;
            $display("FAILED at %0t: output moved to %h flags %b while outValid was low",
                     $time, result, flags);
        end
    end

    initial
    begin
        stimEntry_t  item;
        logic [32:0] wide;
        rst         = 1'b1;
        inValid     = 1'b0;
        instruction = '0;
        rsValue     = '0;
        rtValue     = '0;
        fillTable();
        tableReady = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        foreach (stimTable[i])
            driveItem(stimTable[i]);

        // Reset with a NOR item still in flight, it must never come out
        @(posedge clk);
        instruction <= rType(OP_SPECIAL, FN_NOR, 0);
        @(posedge clk);
        rst     <= 1'b1;
        inValid <= 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // Random ADDU, XOR and SLTU with gaps in the stream
        for (int n = 0; n < NUM_RANDOM; n++)
        begin
            rngState      = xorshift(rngState);
            item.rsValue  = rngState;
            rngState      = xorshift(rngState);
            item.rtValue  = rngState;
            wide          = {1'b0, item.rsValue} + {1'b0, item.rtValue};
            item.expFlags = '0;
            case (rngState % 3)
                0:
                begin
                    item.instruction    = rType(OP_SPECIAL, FN_ADDU, 0);
                    item.expResult      = wide[31:0];
                    item.expFlags.carry = wide[32];
                end
                1:
                begin
                    item.instruction = rType(OP_SPECIAL, FN_XOR, 0);
                    item.expResult   = item.rsValue ^ item.rtValue;
                end
                default:
                begin
                    item.instruction = rType(OP_SPECIAL, FN_SLTU, 0);
                    item.expResult   = (item.rsValue < item.rtValue) ? 32'd1 : 32'd0;
                end
            endcase
            item.expFlags.zero     = (item.expResult == 32'd0);
            item.expFlags.negative = item.expResult[31];
            if (rngState[9])
            begin
                @(posedge clk);
                inValid <= 1'b0; // Idle cycle
                rsValue <= ~rsValue; // Payload changes, output must hold
            end
            driveItem(item);
        end
        @(posedge clk);
        inValid <= 1'b0;

        while (expectQ.size() != 0)
            @(negedge clk);
        repeat (2) @(negedge clk);  // Catch any stray outValid
        $display("Items %0d passed, %0d wrong, %0d assertion failures",
                 passCount, failCount, DUT.flagCheck.assertErrors);
        if (failCount == 0 && DUT.flagCheck.assertErrors == 0 &&
            passCount == stimTable.size() + NUM_RANDOM)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    // Watchdog, every item may carry one idle cycle, plus reset and drain
    initial
    begin
        int limitCycles;
        while (!tableReady)
            @(posedge clk);
        limitCycles = stimTable.size() + 2 * NUM_RANDOM + 20;
        #(limitCycles * CLK_PERIOD);
        $display("Timeout after %0d cycles, outValid never came for %0d pending items",
                 limitCycles, expectQ.size());
        $display("tests failed");
        $finish;
    end

endmodule

/* verification/aluExecute_checker.sv */
`timescale 1ns/10ps

module aluExecute_checker (
    input logic              clk,
    input logic              rst,
    input logic              inValid,
    input logic              outValid,
    input aluPkg::word_t     result,
    input aluPkg::aluFlags_t flags
);

    int assertErrors = 0;  // Read by the testbench summary

    // Output strobe drops right after reset
    resetClears: assert property (@(posedge clk) rst |=> !outValid)
    else
    begin
        assertErrors++;
        $error("outValid high in the cycle after reset");
    end

    // Fixed two-cycle latency, no stalls
    strobeLatency: assert property (@(posedge clk) disable iff (rst)
        outValid == $past(inValid, 2))
    else
    begin
        assertErrors++;
        $error("outValid does not follow inValid by 2 cycles");
    end

    zeroFlag: assert property (@(posedge clk) disable iff (rst)
        outValid |-> (flags.zero == (result == '0)))
    else
    begin
        assertErrors++;
        $error("zero flag disagrees with result");
    end

endmodule

bind aluExecute aluExecute_checker flagCheck (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .outValid (outValid),
    .result   (result),
    .flags    (flags)
);
